//--- src/mcontr_pkg.sv
/* shared definitions for the ddr3 sequencer core
   - bus, address, command word, channel, pause and delay types
   - sequencer state enum
   - command word field positions
   - programming addresses, sub-addresses and defaults */
package mcontr_pkg;

    typedef logic [7:0]  ad_byte_t;              // programming bus byte
    typedef logic [15:0] reg_addr_t;             // full command address
    typedef logic [31:0] cmd_word_t;             // sequencer command word
    typedef logic [9:0]  mem_addr_t;             // command memory word address
    typedef logic [10:0] run_addr_t;             // {bank, word address}
    typedef logic [3:0]  chn_t;                  // buffer channel
    typedef logic [9:0]  pause_t;                // nop pause length
    typedef logic [3:0]  dly_t;                  // write buffer delay

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    localparam int MEM_DEPTH   = 1024;           // words per command memory
    localparam int PAUSE_W     = 10;
    localparam int WBUF_STAGES = 16;             // longest buffer write delay

    // command word layout
    localparam int CW_RCW_LSB       = 0;         // {ras, cas, we}
    localparam int CW_PAUSE_LSB     = 3;
    localparam int CW_DONE_BIT      = 13;
    localparam int CW_ADD_PAUSE_BIT = 14;
    localparam int CW_BUF_WR_BIT    = 15;
    localparam int CW_BUF_RD_BIT    = 16;
    localparam int CW_BUF_RST_BIT   = 17;        // next buffer page
    localparam logic [2:0] RCW_NOP  = 3'b111;

    localparam reg_addr_t PHY_0BIT_ADDR  = 16'h1020;
    localparam reg_addr_t PHY_0BIT_MASK  = 16'hfff0;
    localparam reg_addr_t PHY_16BIT_ADDR = 16'h1050;
    localparam reg_addr_t PHY_16BIT_MASK = 16'hfff8;

    localparam logic [3:0] SUB_CMDA_EN    = 4'h4; // lsb is the new flag value
    localparam logic [3:0] SUB_SDRST_ACT  = 4'h6;
    localparam logic [3:0] SUB_CKE_EN     = 4'h8;
    localparam logic [2:0] SUB_WBUF_DELAY = 3'h2;

    localparam dly_t DFLT_WBUF_DELAY = 4'h8;

endpackage

//--- src/cmd_deser.sv
/* byte-serial command deserializer
   - byte counter started by the strobe
   - address/data shift register
   - masked address match and write pulse */
`timescale 1ns/1ps

module cmd_deser #(
    parameter mcontr_pkg::reg_addr_t BASE_ADDR = 16'h0000,
    parameter mcontr_pkg::reg_addr_t ADDR_MASK = 16'hffff,
    parameter int NUM_BYTES  = 2,                // address bytes plus data bytes
    parameter int SUB_WIDTH  = 4,
    parameter int DATA_WIDTH = 0
) (
    input  logic                                    mclk,
    input  logic                                    rst,
    input  mcontr_pkg::ad_byte_t                    ad_i,
    input  logic                                    stb_i,
    output logic [SUB_WIDTH-1:0]                    sub_addr_o,
    output logic [(DATA_WIDTH > 0 ? DATA_WIDTH : 1)-1:0] data_o,
    output logic                                    we_o
);
    import mcontr_pkg::*;

    localparam int SR_W = NUM_BYTES * 8;
    localparam int DW   = (DATA_WIDTH > 0) ? DATA_WIDTH : 1;

    logic [SR_W-1:0] sr;                         // last byte lands on top
    logic [SR_W-1:0] sr_next;
    logic [2:0]      cnt;                        // bytes taken, 0 when idle
    logic            last;

    assign sr_next    = {ad_i, sr[SR_W-1:8]};
    assign last       = (cnt == 3'(NUM_BYTES - 1)) && !stb_i;
    assign sub_addr_o = sr[SUB_WIDTH-1:0];
    assign data_o     = sr[SR_W-1 -: DW];        // data bytes sit above the address

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            we_o <= 1'b0;
        end else begin
            we_o <= last && ((sr_next[15:0] & ADDR_MASK) == (BASE_ADDR & ADDR_MASK));
            if (stb_i)
                cnt <= 3'd1;                     // address low byte
            else if (last)
                cnt <= '0;
            else if (cnt != '0)
                cnt <= cnt + 3'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (stb_i || cnt != '0)
            sr <= sr_next;                       // hold contents while idle
    end

    // a new command must not cut into one being received
    a_no_restart: assert property (@(posedge mclk) disable iff (rst)
        stb_i |-> cnt == '0);

endmodule

//--- src/phy_ctrl_regs.sv
/* control registers of the sequencer
   - cmda_en, sdram reset and cke flags from 0-bit commands
   - write buffer delay from a 16-bit command */
`timescale 1ns/1ps

module phy_ctrl_regs (
    input  logic             mclk,
    input  logic             rst,
    input  logic             we0_i,
    input  logic [3:0]       sub0_i,
    input  logic             we16_i,
    input  logic [2:0]       sub16_i,
    input  logic [15:0]      data16_i,
    output logic             cmda_en_o,
    output logic             ddr_rst_o,
    output logic             cke_o,
    output mcontr_pkg::dly_t wbuf_delay_o
);
    import mcontr_pkg::*;

    // sub-address bits 3..1 pick the flag, bit 0 is its value
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmda_en_o <= 1'b0;
            ddr_rst_o <= 1'b1;                   // memory held in reset
            cke_o     <= 1'b0;
        end else if (we0_i) begin
            if (sub0_i[3:1] == SUB_CMDA_EN[3:1])
                cmda_en_o <= sub0_i[0];
            if (sub0_i[3:1] == SUB_SDRST_ACT[3:1])
                ddr_rst_o <= sub0_i[0];
            if (sub0_i[3:1] == SUB_CKE_EN[3:1])
                cke_o <= sub0_i[0];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst)
            wbuf_delay_o <= DFLT_WBUF_DELAY;
        else if (we16_i && sub16_i == SUB_WBUF_DELAY)
            wbuf_delay_o <= data16_i[3:0];       // other sub-addresses ignored
    end

endmodule

//--- src/cmd_seq_mem.sv
/* command memory, 1k x 32
   - write port on mclk
   - read port with enabled output register */
`timescale 1ns/1ps

module cmd_seq_mem (
    input  logic                  mclk,
    input  logic                  we_i,
    input  mcontr_pkg::mem_addr_t waddr_i,
    input  mcontr_pkg::cmd_word_t wdata_i,
    input  logic                  ren_i,
    input  mcontr_pkg::mem_addr_t raddr_i,
    output mcontr_pkg::cmd_word_t rdata_o
);
    import mcontr_pkg::*;

    cmd_word_t mem [MEM_DEPTH];

    always_ff @(posedge mclk) begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        if (ren_i)
            rdata_o <= mem[raddr_i];             // holds last word when not reading
    end

endmodule

//--- src/seq_fetch.sv
/* sequencer fetch engine
   - run state, word address and bank select
   - pause counter for nop and add-pause gaps
   - word decode into valid, done and buffer strobes */
`timescale 1ns/1ps

module seq_fetch (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic                  run_seq_i,
    input  mcontr_pkg::run_addr_t run_addr_i,
    input  mcontr_pkg::chn_t      run_chn_i,
    input  logic                  ddr_rst_i,
    input  mcontr_pkg::cmd_word_t rdata0_i,
    input  mcontr_pkg::cmd_word_t rdata1_i,
    output logic                  ren0_o,
    output logic                  ren1_o,
    output mcontr_pkg::mem_addr_t raddr_o,
    output mcontr_pkg::cmd_word_t cmd_o,
    output logic                  cmd_valid_o,
    output logic                  run_busy_o,
    output logic                  run_done_o,
    output logic                  buf_rd_o,
    output logic                  buf_rst_o,
    output logic                  buf_wr_o,
    output mcontr_pkg::chn_t      chn_o
);
    import mcontr_pkg::*;

    seq_state_t state;
    mem_addr_t  addr;                            // next word to read
    logic       bank;                            // 1 reads from cmd1
    logic       fetched;                         // memory output is a fresh word
    pause_t     pause_cntr;                      // read cycles still stalled
    cmd_word_t  word;
    pause_t     pause_len;
    pause_t     pause_load;
    logic       word_nop;
    logic       word_add;
    logic       word_done;
    logic       stall;                           // gap follows this word
    logic       ren;
    logic       take;                            // word goes out next edge

    assign word       = bank ? rdata1_i : rdata0_i;
    assign pause_len  = word[CW_PAUSE_LSB +: PAUSE_W];
    assign word_nop   = word[CW_RCW_LSB +: 3] == RCW_NOP;
    assign word_add   = word[CW_ADD_PAUSE_BIT];
    assign pause_load = pause_len - pause_t'(1) + pause_t'(word_add);
    assign take       = fetched && !ddr_rst_i;
    assign word_done  = fetched && word[CW_DONE_BIT];
    assign stall      = fetched && (word_add || (word_nop && pause_len != '0));

    // one read per cycle unless a gap, the end or a memory reset holds it
    assign ren = (state == SEQ_RUN) && !ddr_rst_i && !stall && !word_done &&
                 !run_done_o && (pause_cntr == '0);

    assign ren0_o     = ren && !bank;
    assign ren1_o     = ren && bank;
    assign raddr_o    = addr;
    assign run_busy_o = state == SEQ_RUN;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state       <= SEQ_IDLE;
            addr        <= '0;
            bank        <= 1'b0;
            chn_o       <= '0;
            fetched     <= 1'b0;
            cmd_valid_o <= 1'b0;
            run_done_o  <= 1'b0;
            buf_rd_o    <= 1'b0;
            buf_rst_o   <= 1'b0;
            buf_wr_o    <= 1'b0;
        end else begin
            fetched     <= ren;
            cmd_valid_o <= take;
            run_done_o  <= take && word[CW_DONE_BIT];
            buf_rd_o    <= take && word[CW_BUF_RD_BIT];
            buf_rst_o   <= take && word[CW_BUF_RST_BIT];
            buf_wr_o    <= take && word[CW_BUF_WR_BIT];
            if (ren)
                addr <= addr + 1'b1;
            if (ddr_rst_i) begin
                state <= SEQ_IDLE;               // abort without a done pulse
            end else if (state == SEQ_IDLE && run_seq_i) begin
                state <= SEQ_RUN;
                addr  <= run_addr_i[9:0];
                bank  <= run_addr_i[10];
                chn_o <= run_chn_i;
            end else if (run_done_o) begin
                state <= SEQ_IDLE;
            end
        end
    end

    // nop of length n plus optional add-pause cycle
    always_ff @(posedge mclk or posedge rst) begin
        if (rst)
            pause_cntr <= '0;
        else if (state != SEQ_RUN || ddr_rst_i)
            pause_cntr <= '0;
        else if (stall && word_nop && pause_len != '0)
            pause_cntr <= pause_load;            // first stalled cycle is this one
        else if (pause_cntr != '0)
            pause_cntr <= pause_cntr - pause_t'(1);
    end

    always_ff @(posedge mclk) begin
        if (fetched)
            cmd_o <= word;
    end

    a_valid_in_run: assert property (@(posedge mclk) disable iff (rst)
        cmd_valid_o |-> state == SEQ_RUN);
    // done only goes out together with the word that carries it
    a_done_on_word: assert property (@(posedge mclk) disable iff (rst)
        run_done_o |-> cmd_valid_o && cmd_o[CW_DONE_BIT]);

endmodule

//--- src/wbuf_delay_line.sv
/* write buffer strobe delay
   - 16 stage shift of strobe and channel
   - tap chosen by the delay, 0 means 16 */
`timescale 1ns/1ps

module wbuf_delay_line (
    input  logic             mclk,
    input  logic             rst,
    input  mcontr_pkg::dly_t dly_i,
    input  logic             wr_i,
    input  mcontr_pkg::chn_t chn_i,
    output logic             wr_o,
    output mcontr_pkg::chn_t chn_o
);
    import mcontr_pkg::*;

    logic [WBUF_STAGES-1:0] wr_sr;
    chn_t                   chn_sr [WBUF_STAGES];
    dly_t                   tap;

    assign tap   = dly_i - 1'b1;                 // stage 0 is one cycle late
    assign wr_o  = wr_sr[tap];
    assign chn_o = chn_sr[tap];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst)
            wr_sr <= '0;
        else
            wr_sr <= {wr_sr[WBUF_STAGES-2:0], wr_i};
    end

    always_ff @(posedge mclk) begin
        chn_sr[0] <= chn_i;
        for (int i = 1; i < WBUF_STAGES; i++)
            chn_sr[i] <= chn_sr[i-1];
    end

endmodule

//--- src/mcontr_sequencer.sv
/* ddr3 sequencer core, top level
   - programming bus decoders and control registers
   - two command memories and the fetch engine
   - write buffer strobe delay */
`timescale 1ns/1ps

module mcontr_sequencer (
    input  logic                  mclk,
    input  logic                  rst,
    input  mcontr_pkg::ad_byte_t  cmd_ad_i,
    input  logic                  cmd_stb_i,
    input  logic                  cmd0_we_i,
    input  mcontr_pkg::mem_addr_t cmd0_addr_i,
    input  mcontr_pkg::cmd_word_t cmd0_data_i,
    input  logic                  cmd1_we_i,
    input  mcontr_pkg::mem_addr_t cmd1_addr_i,
    input  mcontr_pkg::cmd_word_t cmd1_data_i,
    input  mcontr_pkg::run_addr_t run_addr_i,
    input  mcontr_pkg::chn_t      run_chn_i,
    input  logic                  run_seq_i,
    output logic                  run_busy_o,
    output logic                  run_done_o,
    output logic                  mcontr_reset_o,
    output logic                  cmda_en_o,
    output logic                  cke_o,
    output mcontr_pkg::cmd_word_t cmd_o,
    output logic                  cmd_valid_o,
    output logic                  ext_buf_rd_o,
    output logic                  ext_buf_page_nxt_o,
    output mcontr_pkg::chn_t      ext_buf_rchn_o,
    output logic                  ext_buf_wr_o,
    output mcontr_pkg::chn_t      ext_buf_wchn_o
);
    import mcontr_pkg::*;

    logic      we0, we16, ren0, ren1, buf_wr;
    logic [3:0]  sub0;
    logic [2:0]  sub16;
    logic [15:0] data16;
    dly_t      wbuf_delay;
    mem_addr_t raddr;
    cmd_word_t rdata0, rdata1;

    cmd_deser #(
        .BASE_ADDR(PHY_0BIT_ADDR), .ADDR_MASK(PHY_0BIT_MASK),
        .NUM_BYTES(2), .SUB_WIDTH(4), .DATA_WIDTH(0)
    ) deser_0bit_i (
        .mclk(mclk), .rst(rst), .ad_i(cmd_ad_i), .stb_i(cmd_stb_i),
        .sub_addr_o(sub0), .data_o(), .we_o(we0)   // flags carry no data
    );

    cmd_deser #(
        .BASE_ADDR(PHY_16BIT_ADDR), .ADDR_MASK(PHY_16BIT_MASK),
        .NUM_BYTES(4), .SUB_WIDTH(3), .DATA_WIDTH(16)
    ) deser_16bit_i (
        .mclk(mclk), .rst(rst), .ad_i(cmd_ad_i), .stb_i(cmd_stb_i),
        .sub_addr_o(sub16), .data_o(data16), .we_o(we16)
    );

    phy_ctrl_regs regs_i (
        .mclk(mclk), .rst(rst), .we0_i(we0), .sub0_i(sub0),
        .we16_i(we16), .sub16_i(sub16), .data16_i(data16),
        .cmda_en_o(cmda_en_o), .ddr_rst_o(mcontr_reset_o), .cke_o(cke_o),
        .wbuf_delay_o(wbuf_delay)
    );

    cmd_seq_mem cmd0_mem_i (
        .mclk(mclk), .we_i(cmd0_we_i), .waddr_i(cmd0_addr_i), .wdata_i(cmd0_data_i),
        .ren_i(ren0), .raddr_i(raddr), .rdata_o(rdata0)
    );

    cmd_seq_mem cmd1_mem_i (
        .mclk(mclk), .we_i(cmd1_we_i), .waddr_i(cmd1_addr_i), .wdata_i(cmd1_data_i),
        .ren_i(ren1), .raddr_i(raddr), .rdata_o(rdata1)
    );

    seq_fetch fetch_i (
        .mclk(mclk), .rst(rst), .run_seq_i(run_seq_i), .run_addr_i(run_addr_i),
        .run_chn_i(run_chn_i), .ddr_rst_i(mcontr_reset_o),
        .rdata0_i(rdata0), .rdata1_i(rdata1), .ren0_o(ren0), .ren1_o(ren1),
        .raddr_o(raddr), .cmd_o(cmd_o), .cmd_valid_o(cmd_valid_o),
        .run_busy_o(run_busy_o), .run_done_o(run_done_o),
        .buf_rd_o(ext_buf_rd_o), .buf_rst_o(ext_buf_page_nxt_o), .buf_wr_o(buf_wr),
        .chn_o(ext_buf_rchn_o)
    );

    // lines the buffer write up with the memory read latency
    wbuf_delay_line wbuf_dly_i (
        .mclk(mclk), .rst(rst), .dly_i(wbuf_delay), .wr_i(buf_wr),
        .chn_i(ext_buf_rchn_o), .wr_o(ext_buf_wr_o), .chn_o(ext_buf_wchn_o)
    );

endmodule

//--- include/tb_ref_model.svh
/* reference model for the sequencer testbench
   - command memory image type
   - gap rule and expected word list of a run
   - 0-bit flag update and expected buffer write cycles */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef mcontr_pkg::cmd_word_t ref_img_t [mcontr_pkg::MEM_DEPTH];

// idle cycles after a word, nop length plus add-pause
function automatic int ref_gap(input mcontr_pkg::cmd_word_t w);
    int gap;
    gap = w[mcontr_pkg::CW_ADD_PAUSE_BIT];
    if (w[mcontr_pkg::CW_RCW_LSB +: 3] == mcontr_pkg::RCW_NOP)
        gap += w[mcontr_pkg::CW_PAUSE_LSB +: mcontr_pkg::PAUSE_W];
    return gap;
endfunction

// words issued from start up to and including the done word
function automatic void ref_run(input ref_img_t img, input mcontr_pkg::mem_addr_t start,
                                ref mcontr_pkg::cmd_word_t words[$], ref int gaps[$]);
    mcontr_pkg::mem_addr_t a;
    words.delete();
    gaps.delete();
    a = start;
    for (int n = 0; n < mcontr_pkg::MEM_DEPTH; n++) begin
        words.push_back(img[a]);
        gaps.push_back(ref_gap(img[a]));
        if (img[a][mcontr_pkg::CW_DONE_BIT])
            break;
        a = a + 1'b1;                            // address wraps in the bank
    end
endfunction

// flags packed as {cke, sdrst, cmda_en}, reset value 3'b010
function automatic logic [2:0] ref_flags(input logic [2:0] flags,
                                         input mcontr_pkg::reg_addr_t addr);
    logic [2:0] f;
    f = flags;
    if ((addr & mcontr_pkg::PHY_0BIT_MASK) ==
        (mcontr_pkg::PHY_0BIT_ADDR & mcontr_pkg::PHY_0BIT_MASK)) begin
        if (addr[3:1] == mcontr_pkg::SUB_CMDA_EN[3:1])
            f[0] = addr[0];
        if (addr[3:1] == mcontr_pkg::SUB_SDRST_ACT[3:1])
            f[1] = addr[0];
        if (addr[3:1] == mcontr_pkg::SUB_CKE_EN[3:1])
            f[2] = addr[0];
    end
    return f;
endfunction

// ext_buf_wr_o cycles, counted from the cycle of the first issued word
function automatic void ref_wr_cycles(input mcontr_pkg::cmd_word_t words[$], input int gaps[$],
                                      input mcontr_pkg::dly_t dly, ref int cycles[$]);
    int t;
    int d;
    cycles.delete();
    t = 0;
    d = (dly == 0) ? mcontr_pkg::WBUF_STAGES : int'(dly);
    foreach (words[i]) begin
        if (words[i][mcontr_pkg::CW_BUF_WR_BIT])
            cycles.push_back(t + d);
        t += 1 + gaps[i];
    end
endfunction

`endif

//--- bench/tb_mcontr_sequencer.sv
/* testbench for the ddr3 sequencer core
   - clock, reset, programming bus and memory load drivers
   - random command programs in both memories
   - per-cycle compare of issued words, strobes and flags */
`timescale 1ns/1ps

module tb_mcontr_sequencer;
    import mcontr_pkg::*;

    `include "tb_ref_model.svh"

    localparam int TMO = 2000;                   // cycles allowed for any wait

    logic       mclk, rst, cmd_stb_i, run_seq_i;
    ad_byte_t   cmd_ad_i;
    logic       cmd0_we_i, cmd1_we_i;
    mem_addr_t  cmd0_addr_i, cmd1_addr_i;
    cmd_word_t  cmd0_data_i, cmd1_data_i;
    run_addr_t  run_addr_i;
    chn_t       run_chn_i;
    logic       run_busy_o, run_done_o, mcontr_reset_o, cmda_en_o, cke_o;
    cmd_word_t  cmd_o;
    logic       cmd_valid_o, ext_buf_rd_o, ext_buf_page_nxt_o, ext_buf_wr_o;
    chn_t       ext_buf_rchn_o, ext_buf_wchn_o;

    ref_img_t   img0, img1;                      // copies of both memories
    cmd_word_t  exp_words[$];
    int         exp_gaps[$];
    int         exp_wr[$];                       // ext_buf_wr_o cycles
    chn_t       exp_chn;
    dly_t       cur_dly;
    logic [2:0] flags;                           // {cke, sdrst, cmda_en}
    bit         cmp_req, cmp_done;
    int         test_errs, tests_run, tests_bad;

    mcontr_sequencer DUT (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    task automatic tick(input int n);            // n rising edges, then drive delay
        repeat (n) @(posedge mclk);
        #10;
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    task automatic check_val(input string sig, input logic [31:0] got,
                             input logic [31:0] want);
        assert (got === want) else begin
            $display("FAILED %s got %h expected %h", sig, got, want);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    function automatic bit in_list(input int q[$], input int v);
        foreach (q[i])
            if (q[i] == v)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic send_cmd(input reg_addr_t addr, input logic [15:0] data, input bit wide);
        cmd_stb_i = 1'b1;
        cmd_ad_i  = addr[7:0];                   // low byte goes with the strobe
        tick(1);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = addr[15:8];
        tick(1);
        if (wide) begin
            cmd_ad_i = data[7:0];
            tick(1);
            cmd_ad_i = data[15:8];
            tick(1);
        end
        cmd_ad_i = '0;
        tick(4);                                 // both decoders back to idle
    endtask

    task automatic send_flag(input reg_addr_t addr);
        send_cmd(addr, 16'h0, 1'b0);
        flags = ref_flags(flags, addr);
        check_val("{cke_o,mcontr_reset_o,cmda_en_o}", {cke_o, mcontr_reset_o, cmda_en_o},
                  flags);
    endtask

    task automatic write_word(input bit bank, input mem_addr_t a, input cmd_word_t w);
        if (bank) begin
            cmd1_we_i   = 1'b1;
            cmd1_addr_i = a;
            cmd1_data_i = w;
            img1[a]     = w;
        end else begin
            cmd0_we_i   = 1'b1;
            cmd0_addr_i = a;
            cmd0_data_i = w;
            img0[a]     = w;
        end
        tick(1);
        cmd0_we_i = 1'b0;
        cmd1_we_i = 1'b0;
    endtask

    task automatic build_prog(input bit bank, input mem_addr_t start, input int len);
        cmd_word_t w;
        for (int i = 0; i < len; i++) begin
            w = $urandom;
            w[CW_PAUSE_LSB +: PAUSE_W] = pause_t'($urandom % 4);   // short gaps
            if ($urandom % 3 == 0)
                w[CW_RCW_LSB +: 3] = RCW_NOP;
            w[CW_DONE_BIT] = (i == len - 1);
            write_word(bank, start + mem_addr_t'(i), w);
        end
    endtask

    // steps through the expected timeline from the first issued word
    task automatic compare_run();
        int   n;
        int   wi;
        int   left;
        int   last_t;
        int   lim;
        logic want_v;
        n      = exp_words.size();
        wi     = 0;
        left   = 0;
        lim    = 0;
        last_t = WBUF_STAGES + 2;                // late write strobes
        foreach (exp_gaps[i])
            last_t += 1 + exp_gaps[i];
        while (!cmd_valid_o && lim < TMO) begin
            @(negedge mclk);
            lim++;
        end
        if (!cmd_valid_o) begin
            report_error("no command word came out after the run strobe");
            return;
        end
        for (int t = 0; t <= last_t; t++) begin
            if (t > 0)
                @(negedge mclk);
            want_v = (wi < n) && (left == 0);
            check_val("cmd_valid_o", cmd_valid_o, want_v);
            check_val("run_busy_o", run_busy_o, wi < n);
            check_val("run_done_o", run_done_o, want_v && wi == n - 1);
            check_val("ext_buf_wr_o", ext_buf_wr_o, in_list(exp_wr, t));
            if (ext_buf_wr_o)
                check_val("ext_buf_wchn_o", ext_buf_wchn_o, exp_chn);
            if (want_v) begin
                check_val("cmd_o", cmd_o, exp_words[wi]);
                check_val("ext_buf_rd_o", ext_buf_rd_o, exp_words[wi][CW_BUF_RD_BIT]);
                check_val("ext_buf_page_nxt_o", ext_buf_page_nxt_o,
                          exp_words[wi][CW_BUF_RST_BIT]);
                check_val("ext_buf_rchn_o", ext_buf_rchn_o, exp_chn);
                left = exp_gaps[wi];
                wi++;
            end else if (left > 0) begin
                left--;
            end
        end
    endtask

    initial begin : compare_proc
        forever begin
            @(negedge mclk);
            if (cmp_req) begin
                cmp_req = 1'b0;
                compare_run();
                cmp_done = 1'b1;
            end
        end
    end

    task automatic run_and_compare(input run_addr_t ra, input chn_t chn);
        int t;
        if (ra[10])
            ref_run(img1, ra[9:0], exp_words, exp_gaps);
        else
            ref_run(img0, ra[9:0], exp_words, exp_gaps);
        ref_wr_cycles(exp_words, exp_gaps, cur_dly, exp_wr);
        exp_chn    = chn;
        run_addr_i = ra;
        run_chn_i  = chn;
        run_seq_i  = 1'b1;
        cmp_done   = 1'b0;
        cmp_req    = 1'b1;
        tick(1);
        run_seq_i  = 1'b0;
        t = 0;
        while (!cmp_done && t < 2 * TMO) begin
            tick(1);
            t++;
        end
        if (!cmp_done)
            report_error("compare of the run did not finish in time");
    endtask

    initial begin : stimulus
        reg_addr_t   flag_seq [10];
        run_addr_t   ra;
        logic [15:0] data;
        int          t;
        flag_seq = '{16'h1025, 16'h1029, 16'h1026, 16'h1034, 16'h1024,
                     16'h1127, 16'h102e, 16'h1028, 16'h1025, 16'h1029};
        void'($urandom(32'hb06c));
        rst         = 1'b1;
        cmd_ad_i    = '0;
        cmd_stb_i   = 1'b0;
        cmd0_we_i   = 1'b0;
        cmd1_we_i   = 1'b0;
        cmd0_addr_i = '0;
        cmd1_addr_i = '0;
        cmd0_data_i = '0;
        cmd1_data_i = '0;
        run_addr_i  = '0;
        run_chn_i   = '0;
        run_seq_i   = 1'b0;
        flags       = 3'b010;                    // memory reset active
        cur_dly     = DFLT_WBUF_DELAY;
        repeat (5) @(posedge mclk);
        #10;
        rst = 1'b0;
        tick(1);

        check_val("mcontr_reset_o", mcontr_reset_o, 1);
        check_val("cmda_en_o", cmda_en_o, 0);
        check_val("cke_o", cke_o, 0);
        check_val("run_busy_o", run_busy_o, 0);
        end_test("reset values");

        foreach (flag_seq[i])
            send_flag(flag_seq[i]);              // ends with sdrst released
        end_test("0-bit flags");

        ra = {1'b0, mem_addr_t'($urandom)};
        build_prog(1'b0, ra[9:0], 4 + $urandom % 9);
        run_and_compare(ra, chn_t'($urandom));
        end_test("bank 0 run");

        ra = {1'b1, mem_addr_t'($urandom)};
        build_prog(1'b0, ra[9:0], 4 + $urandom % 9);   // decoy at the same address
        build_prog(1'b1, ra[9:0], 4 + $urandom % 9);
        run_and_compare(ra, chn_t'($urandom));
        end_test("bank 1 run");

        repeat (3) begin
            data      = 16'($urandom);
            cur_dly   = dly_t'($urandom);
            data[3:0] = cur_dly;
            send_cmd(PHY_16BIT_ADDR | 16'(SUB_WBUF_DELAY), data, 1'b1);
            send_cmd(PHY_16BIT_ADDR | 16'h3, 16'($urandom), 1'b1);  // not the delay
            ra = {1'b0, mem_addr_t'($urandom)};
            build_prog(1'b0, ra[9:0], 4 + $urandom % 9);
            run_and_compare(ra, chn_t'($urandom));
        end
        end_test("write buffer delay");

        write_word(1'b0, 10'd0, {18'd0, 1'b0, 10'd200, RCW_NOP});   // long nop
        write_word(1'b0, 10'd1, {18'd0, 1'b1, 10'd0, 3'b000});
        run_addr_i = '0;
        run_seq_i  = 1'b1;
        tick(1);
        run_seq_i  = 1'b0;
        t = 0;
        while (!run_busy_o && t < TMO) begin
            tick(1);
            t++;
        end
        if (!run_busy_o)
            report_error("run did not start before the abort");
        send_flag(16'h1027);                     // memory reset in mid pause
        t = 0;
        while (run_busy_o && t < TMO) begin
            tick(1);
            t++;
        end
        if (run_busy_o)
            report_error("run_busy_o stayed high under memory reset");
        run_seq_i = 1'b1;                        // must be ignored
        tick(1);
        run_seq_i = 1'b0;
        repeat (250) begin
            check_val("run_busy_o", run_busy_o, 0);
            check_val("run_done_o", run_done_o, 0);
            tick(1);
        end
        send_flag(16'h1026);
        check_val("run_busy_o", run_busy_o, 0);
        ra = {1'b1, mem_addr_t'($urandom)};
        build_prog(1'b1, ra[9:0], 4 + $urandom % 9);
        run_and_compare(ra, chn_t'($urandom));
        end_test("abort by memory reset");

        $display("%0d tests run, %0d with errors", tests_run, tests_bad);
        if (tests_bad == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
src/mcontr_pkg.sv
src/cmd_deser.sv
src/phy_ctrl_regs.sv
src/cmd_seq_mem.sv
src/seq_fetch.sv
src/wbuf_delay_line.sv
src/mcontr_sequencer.sv
bench/tb_mcontr_sequencer.sv

//--- Bender.yml
package:
  name: mcontr_sequencer

sources:
  - files:
      - src/mcontr_pkg.sv
      - src/cmd_deser.sv
      - src/phy_ctrl_regs.sv
      - src/cmd_seq_mem.sv
      - src/seq_fetch.sv
      - src/wbuf_delay_line.sv
      - src/mcontr_sequencer.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_mcontr_sequencer.sv
